// ==== src/enc_pkg.sv ====
package enc_pkg;

	// sensor count and derived index width.
	localparam int num_channels = 2;
	localparam int chan_bits = (num_channels > 1) ? $clog2(num_channels) : 1;

	// as5311 ssi frame, 12 bits position plus status and parity.
	localparam int frame_bits = 18;
	localparam int frame_cnt_bits = $clog2(frame_bits + 1);

	localparam logic [7:0] op_config = 8'h30;
	localparam logic [7:0] rsp_enc_data = 8'h31;

	typedef logic [chan_bits-1:0] chan_t;

	// first argument word of every command.
	typedef struct packed {
		logic [7:0] opcode;
		logic [23-chan_bits:0] reserved;
		chan_t chan;
	} cmd_header_t;

	// intervals are in systime ticks, zero turns that read off.
	typedef struct packed {
		logic [11:0] divider;
		logic [31:0] data_interval;
		logic [31:0] mag_interval;
	} chan_cfg_t;

	typedef struct packed {
		logic [31:0] start_time;
		logic [frame_bits-1:0] frame;
		logic is_data;
	} enc_report_t;

	typedef struct packed {
		logic [31:0] data;
		logic last;
	} rsp_word_t;

endpackage

// ==== src/enc_cmd_decoder.sv ====
`timescale 1ns/100ps

module enc_cmd_decoder (
	input logic clk,
	input logic reset,
	input logic arg_valid,
	input logic [31:0] arg_data,
	output logic arg_ready,
	output logic cmd_done,
	output enc_pkg::chan_cfg_t cfg [enc_pkg::num_channels],
	output logic [enc_pkg::num_channels-1:0] cfg_load
);

	typedef enum logic [1:0] {
		st_header,
		st_divider,
		st_data_int,
		st_mag_int
	} state_t;

	state_t state;
	enc_pkg::cmd_header_t hdr;
	enc_pkg::chan_t chan;
	logic [11:0] staged_div;
	logic [31:0] staged_data_int;

	// one argument word per cycle, the host is never stalled.
	assign arg_ready = 1'b1;
	assign hdr = arg_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_header;
			cmd_done <= 1'b0;
			cfg_load <= '0;
			for (int i = 0; i < enc_pkg::num_channels; i++) begin
				cfg[i] <= '0;
			end
		end else begin
			cmd_done <= 1'b0;
			cfg_load <= '0;
			if (arg_valid && arg_ready) begin
				case (state)
					st_header: begin
						chan <= hdr.chan;
						if (hdr.opcode == enc_pkg::op_config) begin
							state <= st_divider;
						end else begin
							// unknown opcodes carry no arguments.
							cmd_done <= 1'b1;
						end
					end
					st_divider: begin
						staged_div <= arg_data[11:0];
						state <= st_data_int;
					end
					st_data_int: begin
						staged_data_int <= arg_data;
						state <= st_mag_int;
					end
					default: begin
						// commit all three words at once so the channel
						// never runs on a half written configuration.
						cfg[chan] <= '{
							divider: staged_div,
							data_interval: staged_data_int,
							mag_interval: arg_data
						};
						cfg_load[chan] <= 1'b1;
						cmd_done <= 1'b1;
						state <= st_header;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/ssi_channel.sv ====
`timescale 1ns/100ps

module ssi_channel (
	input logic clk,
	input logic reset,
	input logic [31:0] systime,
	input enc_pkg::chan_cfg_t cfg,
	input logic cfg_load,
	output logic sclk,
	output logic csn,
	input logic dout,
	output logic rep_valid,
	output enc_pkg::enc_report_t rep,
	input logic rep_ready
);

	typedef enum logic [2:0] {
		ph_idle,
		ph_cs_fall,
		ph_clk_fall,
		ph_clk_rise,
		ph_cs_rise,
		ph_tail
	} phase_t;

	phase_t phase;
	logic enabled;
	logic tick;
	logic [11:0] cnt;
	logic [enc_pkg::frame_cnt_bits-1:0] bits_left;
	logic [enc_pkg::frame_bits-1:0] shreg;
	logic [enc_pkg::frame_bits-1:0] prev_data;
	logic [enc_pkg::frame_bits-1:0] prev_mag;
	logic changed;
	logic [31:0] next_data;
	logic [31:0] next_mag;
	logic data_due;
	logic mag_due;
	logic data_pend;
	logic mag_pend;
	logic [31:0] t_start;
	logic cur_is_data;
	enc_pkg::enc_report_t held;
	logic held_valid;

	assign enabled = cfg.divider != 12'd0;
	assign tick = cnt == 12'd1;
	assign changed = cur_is_data ? (shreg != prev_data) : (shreg != prev_mag);
	assign data_due = enabled && !cfg_load && cfg.data_interval != 32'd0 &&
		systime == next_data;
	assign mag_due = enabled && !cfg_load && cfg.mag_interval != 32'd0 &&
		systime == next_mag;

	// interval timers.
	always_ff @(posedge clk) begin
		if (cfg_load) begin
			next_data <= systime + cfg.data_interval;
			next_mag <= systime + cfg.mag_interval;
		end else begin
			if (data_due)
				next_data <= next_data + cfg.data_interval;
			if (mag_due)
				next_mag <= next_mag + cfg.mag_interval;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= ph_idle;
			csn <= 1'b1;
			sclk <= 1'b1;
			data_pend <= 1'b0;
			mag_pend <= 1'b0;
			rep_valid <= 1'b0;
			held_valid <= 1'b0;
			prev_data <= '1;
			prev_mag <= '1;
		end else begin
			// report slot, a held report moves up once the slot is free.
			if (rep_valid && rep_ready) begin
				rep_valid <= 1'b0;
			end else if (!rep_valid && held_valid) begin
				rep <= held;
				rep_valid <= 1'b1;
				held_valid <= 1'b0;
			end

			if (phase != ph_idle && !tick)
				cnt <= cnt - 12'd1;

			if (!enabled) begin
				phase <= ph_idle;
				csn <= 1'b1;
				sclk <= 1'b1;
				data_pend <= 1'b0;
				mag_pend <= 1'b0;
			end else begin
				case (phase)
					ph_idle: begin
						if ((data_pend || mag_pend) && !held_valid) begin
							t_start <= systime;
							cur_is_data <= data_pend;
							if (data_pend)
								data_pend <= 1'b0;
							else
								mag_pend <= 1'b0;
							cnt <= cfg.divider;
							phase <= ph_cs_fall;
						end
					end
					ph_cs_fall: begin
						if (tick) begin
							csn <= 1'b0;
							cnt <= cfg.divider;
							bits_left <= enc_pkg::frame_cnt_bits'(enc_pkg::frame_bits);
							phase <= ph_clk_fall;
						end
					end
					ph_clk_fall: begin
						if (tick) begin
							sclk <= 1'b0;
							cnt <= cfg.divider;
							phase <= ph_clk_rise;
						end
					end
					ph_clk_rise: begin
						if (tick) begin
							// msb first, sampled as sclk goes back high.
							sclk <= 1'b1;
							shreg <= {shreg[enc_pkg::frame_bits-2:0], dout};
							bits_left <= bits_left - enc_pkg::frame_cnt_bits'(1);
							cnt <= cfg.divider;
							phase <= (bits_left == 1) ? ph_cs_rise : ph_clk_fall;
						end
					end
					ph_cs_rise: begin
						if (tick) begin
							csn <= 1'b1;
							cnt <= cfg.divider;
							phase <= ph_tail;
							if (changed) begin
								if (cur_is_data)
									prev_data <= shreg;
								else
									prev_mag <= shreg;
								if (!rep_valid) begin
									rep <= '{start_time: t_start, frame: shreg,
										is_data: cur_is_data};
									rep_valid <= 1'b1;
								end else begin
									held <= '{start_time: t_start, frame: shreg,
										is_data: cur_is_data};
									held_valid <= 1'b1;
								end
							end
						end
					end
					default: begin
						if (tick)
							phase <= ph_idle;
					end
				endcase
			end

			// set last so a request due in the start cycle is not lost.
			if (data_due)
				data_pend <= 1'b1;
			if (mag_due)
				mag_pend <= 1'b1;
		end
	end

endmodule

// ==== src/rsp_arbiter.sv ====
`timescale 1ns/100ps

module rsp_arbiter (
	input logic clk,
	input logic reset,
	input logic [enc_pkg::num_channels-1:0] rep_valid,
	input enc_pkg::enc_report_t rep [enc_pkg::num_channels],
	output logic [enc_pkg::num_channels-1:0] rep_ready,
	output logic rsp_valid,
	output enc_pkg::rsp_word_t rsp,
	input logic rsp_ready
);

	enc_pkg::chan_t last;
	enc_pkg::chan_t pick;
	enc_pkg::chan_t cur_chan;
	enc_pkg::enc_report_t cur;
	logic found;
	logic [1:0] word;

	// round robin, search starts just after the last channel served.
	always_comb begin
		int idx;
		found = 1'b0;
		pick = last;
		for (int k = 1; k <= enc_pkg::num_channels; k++) begin
			idx = (int'(last) + k) % enc_pkg::num_channels;
			if (!found && rep_valid[idx]) begin
				found = 1'b1;
				pick = enc_pkg::chan_t'(idx);
			end
		end
	end

	always_comb begin
		rep_ready = '0;
		if (!rsp_valid && found)
			rep_ready[pick] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			word <= 2'd0;
			last <= enc_pkg::chan_t'(enc_pkg::num_channels - 1);
		end else if (!rsp_valid) begin
			if (found) begin
				cur <= rep[pick];
				cur_chan <= pick;
				last <= pick;
				word <= 2'd0;
				rsp_valid <= 1'b1;
			end
		end else if (rsp_ready) begin
			if (word == 2'd3)
				rsp_valid <= 1'b0;
			word <= word + 2'd1;
		end
	end

	always_comb begin
		rsp.last = 1'b0;
		case (word)
			2'd0: begin
				rsp.data = '0;
				rsp.data[15:8] = enc_pkg::rsp_enc_data;
				rsp.data[enc_pkg::chan_bits-1:0] = cur_chan;
			end
			2'd1: rsp.data = cur.start_time;
			2'd2: rsp.data = 32'(cur.frame);
			default: begin
				rsp.data = 32'(cur.is_data);
				rsp.last = 1'b1;
			end
		endcase
	end

endmodule

// ==== src/enc_top.sv ====
`timescale 1ns/100ps

module enc_top (
	input logic clk,
	input logic reset,
	input logic [31:0] systime,
	input logic arg_valid,
	input logic [31:0] arg_data,
	output logic arg_ready,
	output logic cmd_done,
	output logic rsp_valid,
	output enc_pkg::rsp_word_t rsp,
	input logic rsp_ready,
	output logic [enc_pkg::num_channels-1:0] sclk,
	output logic [enc_pkg::num_channels-1:0] csn,
	input logic [enc_pkg::num_channels-1:0] dout
);

	enc_pkg::chan_cfg_t cfg [enc_pkg::num_channels];
	enc_pkg::enc_report_t rep [enc_pkg::num_channels];
	logic [enc_pkg::num_channels-1:0] cfg_load;
	logic [enc_pkg::num_channels-1:0] rep_valid;
	logic [enc_pkg::num_channels-1:0] rep_ready;

	enc_cmd_decoder decoder0 (
		.clk(clk),
		.reset(reset),
		.arg_valid(arg_valid),
		.arg_data(arg_data),
		.arg_ready(arg_ready),
		.cmd_done(cmd_done),
		.cfg(cfg),
		.cfg_load(cfg_load)
	);

	for (genvar i = 0; i < enc_pkg::num_channels; i++) begin : g_chan
		ssi_channel chan0 (
			.clk(clk),
			.reset(reset),
			.systime(systime),
			.cfg(cfg[i]),
			.cfg_load(cfg_load[i]),
			.sclk(sclk[i]),
			.csn(csn[i]),
			.dout(dout[i]),
			.rep_valid(rep_valid[i]),
			.rep(rep[i]),
			.rep_ready(rep_ready[i])
		);
	end

	rsp_arbiter arbiter0 (
		.clk(clk),
		.reset(reset),
		.rep_valid(rep_valid),
		.rep(rep),
		.rep_ready(rep_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.rsp_ready(rsp_ready)
	);

endmodule

// ==== tests/as5311_model.sv ====
`timescale 1ns/100ps

module as5311_model (
	input logic csn,
	input logic sclk,
	input logic [enc_pkg::frame_bits-1:0] value,
	output logic dout
);

	logic [enc_pkg::frame_bits-1:0] shadow;
	int idx;
	logic first;

	initial begin
		dout = 1'b1;
		idx = enc_pkg::frame_bits - 1;
		first = 1'b0;
		shadow = '1;
	end

	// the value is captured at frame start, so a change lands on the next read.
	always @(negedge csn) begin
		shadow = value;
		idx = enc_pkg::frame_bits - 1;
		first = 1'b1;
		dout = value[enc_pkg::frame_bits-1];
	end

	// msb is already out, the first falling sclk keeps it.
	always @(negedge sclk) begin
		if (!csn) begin
			if (first) begin
				first = 1'b0;
			end else if (idx > 0) begin
				idx = idx - 1;
				dout = shadow[idx];
			end
		end
	end

endmodule

// ==== tests/tb_enc_top.sv ====
`timescale 1ns/100ps

module tb_enc_top;

	logic clk;
	logic reset;
	logic [31:0] systime;
	logic arg_valid;
	logic [31:0] arg_data;
	logic arg_ready;
	logic cmd_done;
	logic rsp_valid;
	enc_pkg::rsp_word_t rsp;
	logic rsp_ready;
	logic [enc_pkg::num_channels-1:0] sclk;
	logic [enc_pkg::num_channels-1:0] csn;
	logic [enc_pkg::num_channels-1:0] dout;
	logic [enc_pkg::frame_bits-1:0] val [enc_pkg::num_channels];
	logic [31:0] seed;
	int errors;

	enc_top dut0 (
		.clk(clk), .reset(reset), .systime(systime),
		.arg_valid(arg_valid), .arg_data(arg_data), .arg_ready(arg_ready),
		.cmd_done(cmd_done), .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
		.sclk(sclk), .csn(csn), .dout(dout)
	);

	for (genvar i = 0; i < enc_pkg::num_channels; i++) begin : g_sensor
		as5311_model sensor0 (.csn(csn[i]), .sclk(sclk[i]), .value(val[i]), .dout(dout[i]));
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		systime <= reset ? 32'd0 : systime + 32'd1;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// new sensor value, never the old one and never the all ones reset frame.
	function automatic logic [enc_pkg::frame_bits-1:0] fresh_value(
		input logic [enc_pkg::frame_bits-1:0] old);
		logic [31:0] r;
		r = next_random();
		while (r[enc_pkg::frame_bits-1:0] == old || r[enc_pkg::frame_bits-1:0] == '1)
			r = next_random();
		return r[enc_pkg::frame_bits-1:0];
	endfunction

	function automatic int budget(input int interval, input int div);
		return 2 * (interval + 40 * div);
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic send_cmd(input string name, input logic [31:0] w [4], input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			arg_valid <= 1'b1;
			arg_data <= w[i];
			if (i == n - 1) begin
				@(negedge clk);
				check({name, " ready"}, 1, 32'(arg_ready));
				check({name, " done early"}, 0, 32'(cmd_done));
			end
		end
		// the last word transfers on this edge.
		@(posedge clk);
		arg_valid <= 1'b0;
		@(negedge clk);
		check({name, " done"}, 1, 32'(cmd_done));
		@(negedge clk);
		check({name, " done width"}, 0, 32'(cmd_done));
	endtask

	task automatic configure(input string name, input int ch, input int div,
		input int di, input int mi);
		send_cmd(name, '{{enc_pkg::op_config, 24'(ch)}, 32'(div), 32'(di), 32'(mi)}, 4);
	endtask

	task automatic collect(input string name, input int limit, output logic [31:0] w [4]);
		int n;
		int waited;
		n = 0;
		waited = 0;
		while (n < 4 && waited < limit) begin
			@(negedge clk);
			if (rsp_valid && rsp_ready) begin
				w[n] = rsp.data;
				check({name, " last"}, 32'(n == 3), 32'(rsp.last));
				n++;
			end else begin
				waited++;
			end
		end
		if (n < 4) begin
			$display("%s: no complete response within %0d cycles", name, limit);
			errors++;
		end
	endtask

	task automatic check_report(input string name, input logic [31:0] w [4], input int ch,
		input logic [31:0] frame, input logic [31:0] is_data);
		check({name, " header"}, {16'h0, enc_pkg::rsp_enc_data, 8'(ch)}, w[0]);
		check({name, " frame"}, frame, w[2]);
		check({name, " is_data"}, is_data, w[3]);
	endtask

	task automatic quiet(input string name, input int cycles, input logic pins);
		logic bad;
		bad = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (rsp_valid || (pins && (csn != '1 || sclk != '1)))
				bad = 1'b1;
		end
		if (bad) begin
			$display("%s: unexpected response or pin activity", name);
			errors++;
		end
	endtask

	task automatic test_reset();
		@(negedge clk);
		check("reset csn", 32'(2'b11), 32'(csn));
		check("reset sclk", 32'(2'b11), 32'(sclk));
		check("reset rsp_valid", 0, 32'(rsp_valid));
		quiet("reset idle", 200, 1'b1);
	endtask

	task automatic test_commands();
		configure("commands config", 1, 0, 100, 0);
		send_cmd("commands unknown", '{{8'h99, 24'd0}, 32'd0, 32'd0, 32'd0}, 1);
	endtask

	task automatic test_data_read();
		logic [31:0] w [4];
		logic [31:0] seen;
		logic prev;
		int waited;
		val[0] <= fresh_value(val[0]);
		configure("data_read config", 0, 2, 200, 0);
		seen = 0;
		waited = 0;
		prev = csn[0];
		while (waited < 300 && !(prev && !csn[0])) begin
			prev = csn[0];
			@(negedge clk);
			waited++;
		end
		seen = systime;
		if (waited >= 300) begin
			$display("data_read: sensor frame never started");
			errors++;
		end
		collect("data_read", 300, w);
		check_report("data_read", w, 0, 32'(val[0]), 1);
		// systime has already stepped past the edge where csn fell.
		check("data_read start", seen - 32'd3, w[1]);
	endtask

	task automatic test_change_filter();
		logic [31:0] w [4];
		quiet("filter unchanged", 450, 1'b0);
		@(posedge clk);
		val[0] <= fresh_value(val[0]);
		collect("filter change", 300, w);
		check_report("filter change", w, 0, 32'(val[0]), 1);
		quiet("filter single", 250, 1'b0);
		configure("filter mag config", 0, 2, 200, 150);
		collect("filter mag", 400, w);
		check_report("filter mag", w, 0, 32'(val[0]), 0);
		quiet("filter mag single", 350, 1'b0);
	endtask

	task automatic test_two_channels_backpressure();
		logic [31:0] a [4];
		logic [31:0] b [4];
		enc_pkg::rsp_word_t first;
		logic bad;
		int waited;
		@(posedge clk);
		rsp_ready <= 1'b0;
		val[0] <= fresh_value(val[0]);
		val[1] <= fresh_value(val[1]);
		// channel 1 is loaded six cycles later, so both reads fall due together.
		configure("two config0", 0, 1, 46, 0);
		configure("two config1", 1, 1, 40, 0);
		waited = 0;
		while (!rsp_valid && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		first = rsp;
		bad = !rsp_valid;
		repeat (100) begin
			@(negedge clk);
			if (!rsp_valid || rsp != first)
				bad = 1'b1;
		end
		check("two stall hold", 0, 32'(bad));
		@(posedge clk);
		rsp_ready <= 1'b1;
		collect("two first", 100, a);
		collect("two second", 100, b);
		// channel 0 was served last, so channel 1 wins when both wait.
		check("two first chan", 1, 32'(a[0][0]));
		check("two alternate", 32'(!a[0][0]), 32'(b[0][0]));
		check_report("two first", a, int'(a[0][0]), 32'(val[a[0][0]]), 1);
		check_report("two second", b, int'(b[0][0]), 32'(val[b[0][0]]), 1);
	endtask

	task automatic test_disable();
		configure("disable config0", 0, 0, 200, 0);
		configure("disable config1", 1, 0, 200, 0);
		@(posedge clk);
		val[0] <= fresh_value(val[0]);
		val[1] <= fresh_value(val[1]);
		quiet("disable idle", 400, 1'b1);
	endtask

	initial begin
		int limit;
		limit = budget(110, 0) + budget(20, 0) + budget(200, 2) + budget(800, 2) +
			budget(100, 1) + budget(200, 0) + 10;
		repeat (limit) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		systime = 32'd0;
		arg_valid = 1'b0;
		arg_data = 32'd0;
		rsp_ready = 1'b1;
		val[0] = '1;
		val[1] = '1;
		seed = 32'd18;
		errors = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_commands();
		test_data_read();
		test_change_filter();
		test_two_channels_backpressure();
		test_disable();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
src/enc_pkg.sv
src/enc_cmd_decoder.sv
src/ssi_channel.sv
src/rsp_arbiter.sv
src/enc_top.sv
tests/as5311_model.sv
tests/tb_enc_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_enc_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= files.f
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
